/* Makefile */
# Verilator build and run of the DDR4 bank testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check sim.log for the pass line"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f \
		--top-module memoryBankTb -Mdir obj_dir
	./obj_dir/VmemoryBankTb | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

/* design/bankFsm.sv */
`timescale 1ns/1ps
`default_nettype none

module bankFsm (
    input  logic                clk,
    input  logic                rst_n,
    input  ddrCmdPkg::ddrOp_t   op,
    input  bankPkg::timing_t    timing,
    input  logic                burstDone,
    output logic                burstStart,
    output logic                burstWrite
);

    bankPkg::bankState_t state, stateNext;
    // Cycles left in the current timed state
    bankPkg::time_t      cnt, cntNext;
    // Column command waiting for its CL / CWL to expire
    logic                pending, pendingNext;
    // Auto-precharge requested by the column command
    logic                autoPre, autoPreNext;
    // Row open and free for a new command this cycle
    logic                acceptOpen;

    // Mode travels with the start pulse
    assign burstWrite = (state == bankPkg::Write);

    // ----------------------------
    // Next state
    // ----------------------------
    always_comb begin
        stateNext   = state;
        cntNext     = cnt;
        pendingNext = pending;
        autoPreNext = autoPre;
        burstStart  = 1'b0;
        acceptOpen  = 1'b0;
        case (state)
            bankPkg::RowClosed: begin
                // Accept at edge N, free again from edge N+t
                if (op == ddrCmdPkg::OpActivate) begin
                    stateNext = bankPkg::Activate;
                    cntNext   = timing.tRcd - bankPkg::time_t'(2);
                end else if (op == ddrCmdPkg::OpRefresh) begin
                    stateNext = bankPkg::Refresh;
                    cntNext   = timing.tRfc - bankPkg::time_t'(2);
                end
            end
            bankPkg::Activate, bankPkg::Precharge, bankPkg::Refresh: begin
                if (cnt == '0) begin
                    stateNext = (state == bankPkg::Activate) ? bankPkg::RowOpened
                                                             : bankPkg::RowClosed;
                end else begin
                    cntNext = cnt - bankPkg::time_t'(1);
                end
            end
            bankPkg::RowOpened: acceptOpen = 1'b1;
            bankPkg::Read, bankPkg::Write: begin
                if (pending) begin
                    // Start pulse one cycle ahead of beat 0
                    if (cnt == '0) begin
                        burstStart  = 1'b1;
                        pendingNext = 1'b0;
                    end else begin
                        cntNext = cnt - bankPkg::time_t'(1);
                    end
                end else if (burstDone) begin
                    if (autoPre) begin
                        // Burst end edge counts like a PRECHARGE command
                        stateNext   = bankPkg::Precharge;
                        cntNext     = timing.tRp - bankPkg::time_t'(2);
                        autoPreNext = 1'b0;
                    end else begin
                        // Last beat, row counts as open already
                        stateNext  = bankPkg::RowOpened;
                        acceptOpen = 1'b1;
                    end
                end
            end
            default: stateNext = bankPkg::RowClosed;
        endcase

        // Column commands and PRECHARGE on an open row
        if (acceptOpen) begin
            case (op)
                ddrCmdPkg::OpRead, ddrCmdPkg::OpReadAp: begin
                    stateNext   = bankPkg::Read;
                    cntNext     = timing.tCl - bankPkg::time_t'(1);
                    pendingNext = 1'b1;
                    autoPreNext = (op == ddrCmdPkg::OpReadAp);
                end
                ddrCmdPkg::OpWrite, ddrCmdPkg::OpWriteAp: begin
                    stateNext   = bankPkg::Write;
                    cntNext     = timing.tCwl - bankPkg::time_t'(1);
                    pendingNext = 1'b1;
                    autoPreNext = (op == ddrCmdPkg::OpWriteAp);
                end
                ddrCmdPkg::OpPrecharge: begin
                    stateNext = bankPkg::Precharge;
                    cntNext   = timing.tRp - bankPkg::time_t'(2);
                end
                // ACTIVATE and REFRESH on an open row are dropped
                default: ;
            endcase
        end
    end

    // ----------------------------
    // State registers
    // ----------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= bankPkg::RowClosed;
            cnt     <= '0;
            pending <= 1'b0;
            autoPre <= 1'b0;
        end else begin
            state   <= stateNext;
            cnt     <= cntNext;
            pending <= pendingNext;
            autoPre <= autoPreNext;
        end
    end

endmodule

`default_nettype wire

/* design/bankPkg.sv */
`default_nettype none

package bankPkg;

    // ----------------------------
    // Data path
    // ----------------------------
    localparam int DataWidth    = 64;
    localparam int MaskWidth    = DataWidth / 8;
    localparam int BurstLength  = 8;
    localparam int BeatIdxWidth = 3;

    typedef logic [DataWidth-1:0]    beat_t;
    typedef logic [BeatIdxWidth-1:0] beatIdx_t;

    // Index of the final beat of a BL8 burst
    localparam beatIdx_t LastBeat = beatIdx_t'(BurstLength - 1);

    // Write beat with its active-low byte mask (1 keeps the byte written)
    typedef struct packed {
        beat_t                data;
        logic [MaskWidth-1:0] maskN;
    } beatData_t;

    // ----------------------------
    // Timing
    // ----------------------------

    // Wide enough for tRFC
    localparam int TimeWidth = 9;
    typedef logic [TimeWidth-1:0] time_t;

    // Reset values, in clk cycles
    localparam time_t DefTcl  = 16;
    localparam time_t DefTcwl = 12;
    localparam time_t DefTrcd = 16;
    localparam time_t DefTrp  = 16;
    localparam time_t DefTrfc = 256;

    typedef enum logic [2:0] {
        SelTcl,
        SelTcwl,
        SelTrcd,
        SelTrp,
        SelTrfc
    } timingSel_t;

    // All five timing values, 45 bits
    typedef struct packed {
        time_t tCl;
        time_t tCwl;
        time_t tRcd;
        time_t tRp;
        time_t tRfc;
    } timing_t;

    // Row state of the bank
    typedef enum logic [2:0] {
        RowClosed,
        Activate,
        RowOpened,
        Read,
        Write,
        Precharge,
        Refresh
    } bankState_t;

endpackage

`default_nettype wire

/* design/burstStorage.sv */
`timescale 1ns/1ps
`default_nettype none

module burstStorage (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          burstStart,
    input  logic                          burstWrite,
    input  bankPkg::beatData_t            wrBeat,
    output logic [bankPkg::DataWidth-1:0] rdData,
    output logic                          readValid,
    output logic                          writeValid,
    output logic                          burstDone
);

    // One BL8 burst worth of data
    bankPkg::beat_t    mem [bankPkg::BurstLength];
    bankPkg::beatIdx_t beatIdx;
    // Burst in progress
    logic              active;
    // 1 for a write burst
    logic              writeMode;

    // ----------------------------
    // Beat sequencing
    // ----------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active    <= 1'b0;
            writeMode <= 1'b0;
            beatIdx   <= '0;
        end else if (burstStart) begin
            active    <= 1'b1;
            writeMode <= burstWrite;
            beatIdx   <= '0;
        end else if (active) begin
            if (beatIdx == bankPkg::LastBeat) begin
                active  <= 1'b0;
                beatIdx <= '0;
            end else begin
                beatIdx <= beatIdx + bankPkg::beatIdx_t'(1);
            end
        end
    end

    // Known contents out of reset, beat b holds b
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int b = 0; b < bankPkg::BurstLength; b++) begin
                mem[b] <= bankPkg::beat_t'(b);
            end
        end else if (active && writeMode) begin
            // Byte lanes with maskN high take the new data
            for (int i = 0; i < bankPkg::MaskWidth; i++) begin
                if (wrBeat.maskN[i]) begin
                    mem[beatIdx][i*8 +: 8] <= wrBeat.data[i*8 +: 8];
                end
            end
        end
    end

    // DQ is driven only while a read burst is on the bus
    assign rdData     = (active && !writeMode) ? mem[beatIdx] : '0;
    assign readValid  = active && !writeMode;
    assign writeValid = active && writeMode;
    assign burstDone  = active && (beatIdx == bankPkg::LastBeat);

endmodule

`default_nettype wire

/* design/cmdDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module cmdDecoder (
    input  ddrCmdPkg::ddrCmd_t cmd,
    output ddrCmdPkg::ddrOp_t  op
);

    // RAS_n / CAS_n / WE_n as one field
    logic [2:0] rcw;
    // A10 on column commands
    logic       autoPre;
    // Clock enabled and chip selected
    logic       selected;

    assign rcw      = {cmd.addr[ddrCmdPkg::PinRas],
                       cmd.addr[ddrCmdPkg::PinCas],
                       cmd.addr[ddrCmdPkg::PinWe]};
    assign autoPre  = cmd.addr[ddrCmdPkg::PinAp];
    assign selected = cmd.cke && !cmd.csN;

    // ----------------------------
    // Priority decode
    // ----------------------------
    always_comb begin
        op = ddrCmdPkg::OpNop;
        if (selected) begin
            if (!cmd.actN) begin
                // ACT_n low overrides the RAS/CAS/WE meaning of the pins
                op = ddrCmdPkg::OpActivate;
            end else begin
                case (rcw)
                    // Single-bank precharge only, A10 high is not modelled
                    3'b010: op = autoPre ? ddrCmdPkg::OpNop : ddrCmdPkg::OpPrecharge;
                    3'b101: op = autoPre ? ddrCmdPkg::OpReadAp : ddrCmdPkg::OpRead;
                    3'b100: op = autoPre ? ddrCmdPkg::OpWriteAp : ddrCmdPkg::OpWrite;
                    3'b001: op = ddrCmdPkg::OpRefresh;
                    // NOP and reserved patterns
                    default: op = ddrCmdPkg::OpNop;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* design/ddrCmdPkg.sv */
`default_nettype none

package ddrCmdPkg;

    // ----------------------------
    // Command pin layout
    // ----------------------------

    // Width of the shared address / command pins A[17:0]
    localparam int CmdAddrWidth = 18;

    // Address pins that double as command pins when ACT_n is high
    localparam int PinRas = 16;
    localparam int PinCas = 15;
    localparam int PinWe  = 14;
    // A10 selects auto-precharge on column commands
    localparam int PinAp  = 10;

    // One sample of the broadcast command bus, 21 bits
    typedef struct packed {
        logic                    cke;
        logic                    csN;
        logic                    actN;
        logic [CmdAddrWidth-1:0] addr;
    } ddrCmd_t;

    // Decoded command, one per cycle
    typedef enum logic [2:0] {
        OpNop,
        OpActivate,
        OpRead,
        OpReadAp,
        OpWrite,
        OpWriteAp,
        OpPrecharge,
        OpRefresh
    } ddrOp_t;

endpackage

`default_nettype wire

/* design/memoryBank.sv */
`timescale 1ns/1ps
`default_nettype none

module memoryBank (
    input  logic                          clk,
    input  logic                          rst_n,
    input  ddrCmdPkg::ddrCmd_t            cmd,
    input  logic                          cfgWrite,
    input  bankPkg::timingSel_t           cfgSel,
    input  logic [bankPkg::TimeWidth-1:0] cfgValue,
    input  bankPkg::beatData_t            wrBeat,
    output logic [bankPkg::DataWidth-1:0] rdData,
    output logic                          readValid,
    output logic                          writeValid
);

    // ----------------------------
    // Internal nets
    // ----------------------------
    ddrCmdPkg::ddrOp_t op;
    bankPkg::timing_t  timing;
    logic              burstStart;
    logic              burstWrite;
    logic              burstDone;

    // Pins to opcode
    cmdDecoder cmdDecoder_i (.cmd(cmd), .op(op));

    // Run-time CL / CWL / tRCD / tRP / tRFC
    timingRegs timingRegs_i (
        .clk(clk), .rst_n(rst_n), .cfgWrite(cfgWrite), .cfgSel(cfgSel),
        .cfgValue(cfgValue), .timing(timing)
    );

    bankFsm bankFsm_i (
        .clk(clk), .rst_n(rst_n), .op(op), .timing(timing), .burstDone(burstDone),
        .burstStart(burstStart), .burstWrite(burstWrite)
    );

    // Data side of the bank
    burstStorage burstStorage_i (
        .clk(clk), .rst_n(rst_n), .burstStart(burstStart), .burstWrite(burstWrite),
        .wrBeat(wrBeat), .rdData(rdData), .readValid(readValid),
        .writeValid(writeValid), .burstDone(burstDone)
    );

endmodule

`default_nettype wire

/* design/timingRegs.sv */
`timescale 1ns/1ps
`default_nettype none

module timingRegs (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      cfgWrite,
    input  bankPkg::timingSel_t       cfgSel,
    input  logic [bankPkg::TimeWidth-1:0] cfgValue,
    output bankPkg::timing_t          timing
);

    // Written value after clamping
    bankPkg::time_t clamped;

    // The FSM counters need at least two cycles
    assign clamped = (cfgValue < bankPkg::time_t'(2)) ? bankPkg::time_t'(2) : cfgValue;

    // ----------------------------
    // Mode-register style storage
    // ----------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            timing.tCl  <= bankPkg::DefTcl;
            timing.tCwl <= bankPkg::DefTcwl;
            timing.tRcd <= bankPkg::DefTrcd;
            timing.tRp  <= bankPkg::DefTrp;
            timing.tRfc <= bankPkg::DefTrfc;
        end else if (cfgWrite) begin
            // One register per strobe
            case (cfgSel)
                bankPkg::SelTcl:  timing.tCl  <= clamped;
                bankPkg::SelTcwl: timing.tCwl <= clamped;
                bankPkg::SelTrcd: timing.tRcd <= clamped;
                bankPkg::SelTrp:  timing.tRp  <= clamped;
                bankPkg::SelTrfc: timing.tRfc <= clamped;
                // Unused selector codes write nothing
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verif/memoryBankTb.sv */
`timescale 1ns/1ps
`default_nettype none

module memoryBankTb;

    localparam int NumOps     = 300;
    localparam int ClkPeriod  = 40;
    localparam int CycleLimit = NumOps * (bankPkg::DefTrfc + 40);

    logic                          clk;
    logic                          rst_n;
    ddrCmdPkg::ddrCmd_t            cmd;
    logic                          cfgWrite;
    bankPkg::timingSel_t           cfgSel;
    logic [bankPkg::TimeWidth-1:0] cfgValue;
    bankPkg::beatData_t            wrBeat;
    logic [bankPkg::DataWidth-1:0] rdData;
    logic                          readValid;
    logic                          writeValid;

    // ------------------------------
    // Reference model state
    // ------------------------------
    logic [bankPkg::DataWidth-1:0] modelMem [bankPkg::BurstLength];
    int   tCl, tCwl, tRcd, tRp, tRfc;
    logic rowOpen;
    // First edge that may accept a command
    int   busyUntil;
    // Edge that starts beat 0 of the current burst
    int   burstBase;
    logic burstIsWrite;
    int   edgeNum;
    // Prediction for the cycle after the latest edge
    logic expRead, expWrite;
    int   expIdx;
    int   dataErrs, readErrs, writeErrs;
    int   cycleCount = 0;

    memoryBank memoryBank_i (
        .clk(clk), .rst_n(rst_n), .cmd(cmd), .cfgWrite(cfgWrite), .cfgSel(cfgSel),
        .cfgValue(cfgValue), .wrBeat(wrBeat), .rdData(rdData), .readValid(readValid),
        .writeValid(writeValid)
    );

    initial clk = 1'b0;
    always #(ClkPeriod / 2) clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CycleLimit) begin
            $display("Timeout: run did not finish within %0d cycles", CycleLimit);
            $display("Test failed");
            $finish;
        end
    end

    // Pin pattern for one command with the spare address pins random
    function automatic ddrCmdPkg::ddrCmd_t buildCmd(input ddrCmdPkg::ddrOp_t op);
        ddrCmdPkg::ddrCmd_t c;
        logic [2:0]         rcw;
        c.cke  = 1'b1;
        c.csN  = 1'b0;
        c.actN = (op != ddrCmdPkg::OpActivate);
        c.addr = 18'($urandom);
        case (op)
            ddrCmdPkg::OpRead, ddrCmdPkg::OpReadAp:   rcw = 3'b101;
            ddrCmdPkg::OpWrite, ddrCmdPkg::OpWriteAp: rcw = 3'b100;
            ddrCmdPkg::OpPrecharge:                   rcw = 3'b010;
            ddrCmdPkg::OpRefresh:                     rcw = 3'b001;
            default:                                  rcw = 3'b111;
        endcase
        if (op != ddrCmdPkg::OpActivate) begin
            c.addr[ddrCmdPkg::PinRas] = rcw[2];
            c.addr[ddrCmdPkg::PinCas] = rcw[1];
            c.addr[ddrCmdPkg::PinWe]  = rcw[0];
            c.addr[ddrCmdPkg::PinAp]  = (op == ddrCmdPkg::OpReadAp) ||
                                        (op == ddrCmdPkg::OpWriteAp);
        end
        return c;
    endfunction

    // Model decode of the command pins
    function automatic ddrCmdPkg::ddrOp_t decodePins(input ddrCmdPkg::ddrCmd_t c);
        logic [2:0] rcw;
        logic       ap;
        rcw = {c.addr[ddrCmdPkg::PinRas], c.addr[ddrCmdPkg::PinCas], c.addr[ddrCmdPkg::PinWe]};
        ap  = c.addr[ddrCmdPkg::PinAp];
        if (!c.cke || c.csN) return ddrCmdPkg::OpNop;
        if (!c.actN) return ddrCmdPkg::OpActivate;
        if (rcw == 3'b010 && !ap) return ddrCmdPkg::OpPrecharge;
        if (rcw == 3'b101) return ap ? ddrCmdPkg::OpReadAp : ddrCmdPkg::OpRead;
        if (rcw == 3'b100) return ap ? ddrCmdPkg::OpWriteAp : ddrCmdPkg::OpWrite;
        if (rcw == 3'b001) return ddrCmdPkg::OpRefresh;
        return ddrCmdPkg::OpNop;
    endfunction

    // A command the bank accepts once idle
    function automatic ddrCmdPkg::ddrOp_t pickLegalOp();
        int r;
        r = $urandom % 6;
        if (!rowOpen) return (r < 4) ? ddrCmdPkg::OpActivate : ddrCmdPkg::OpRefresh;
        case (r)
            0, 5:    return ddrCmdPkg::OpRead;
            1:       return ddrCmdPkg::OpReadAp;
            2:       return ddrCmdPkg::OpWrite;
            3:       return ddrCmdPkg::OpWriteAp;
            default: return ddrCmdPkg::OpPrecharge;
        endcase
    endfunction

    task automatic startBurst(input logic isWrite, input int latency, input logic ap);
        burstBase    = edgeNum + latency;
        burstIsWrite = isWrite;
        busyUntil    = burstBase + bankPkg::BurstLength;
        // Row closes tRP after the last beat
        if (ap) begin
            rowOpen   = 1'b0;
            busyUntil = busyUntil + tRp;
        end
    endtask

    // Mode register write as seen by commands on later edges
    task automatic applyCfg();
        int v;
        v = (cfgValue < 2) ? 2 : int'(cfgValue);
        case (cfgSel)
            bankPkg::SelTcl:  tCl  = v;
            bankPkg::SelTcwl: tCwl = v;
            bankPkg::SelTrcd: tRcd = v;
            bankPkg::SelTrp:  tRp  = v;
            bankPkg::SelTrfc: tRfc = v;
            default: ;
        endcase
    endtask

    // Model update at one rising edge
    task automatic modelEdge();
        ddrCmdPkg::ddrOp_t op;
        op = decodePins(cmd);
        // Write beat of the cycle that just ended
        if (expWrite) begin
            for (int i = 0; i < bankPkg::MaskWidth; i++) begin
                if (wrBeat.maskN[i]) modelMem[3'(expIdx)][i*8 +: 8] = wrBeat.data[i*8 +: 8];
            end
        end
        if (edgeNum >= busyUntil && !rowOpen) begin
            if (op == ddrCmdPkg::OpActivate) begin
                rowOpen   = 1'b1;
                busyUntil = edgeNum + tRcd;
            end else if (op == ddrCmdPkg::OpRefresh) begin
                busyUntil = edgeNum + tRfc;
            end
        end else if (edgeNum >= busyUntil) begin
            case (op)
                ddrCmdPkg::OpRead:    startBurst(1'b0, tCl, 1'b0);
                ddrCmdPkg::OpReadAp:  startBurst(1'b0, tCl, 1'b1);
                ddrCmdPkg::OpWrite:   startBurst(1'b1, tCwl, 1'b0);
                ddrCmdPkg::OpWriteAp: startBurst(1'b1, tCwl, 1'b1);
                ddrCmdPkg::OpPrecharge: begin
                    rowOpen   = 1'b0;
                    busyUntil = edgeNum + tRp;
                end
                default: ;
            endcase
        end
        if (cfgWrite) applyCfg();
        expIdx   = edgeNum - burstBase;
        expRead  = (expIdx >= 0) && (expIdx < bankPkg::BurstLength) && !burstIsWrite;
        expWrite = (expIdx >= 0) && (expIdx < bankPkg::BurstLength) && burstIsWrite;
    endtask

    task automatic checkOutputs();
        logic [bankPkg::DataWidth-1:0] expData;
        expData = '0;
        if (expRead) expData = modelMem[3'(expIdx)];
        assert (readValid === expRead) else begin
            readErrs++;
            $display("Error: readValid got %h expected %h", readValid, expRead);
        end
        assert (writeValid === expWrite) else begin
            writeErrs++;
            $display("Error: writeValid got %h expected %h", writeValid, expWrite);
        end
        assert (rdData === expData) else begin
            dataErrs++;
            $display("Error: rdData got %h expected %h", rdData, expData);
        end
    endtask

    // Drive inputs 2 ns after an edge and advance one cycle
    task automatic step(input ddrCmdPkg::ddrCmd_t c, input logic cfg);
        cmd          = c;
        cfgWrite     = cfg;
        cfgSel       = bankPkg::timingSel_t'(3'($urandom % 5));
        cfgValue     = bankPkg::TimeWidth'(4 + $urandom % 17);
        wrBeat.data  = {$urandom, $urandom};
        wrBeat.maskN = 8'($urandom);
        @(posedge clk);
        edgeNum++;
        modelEdge();
        #1;
        checkOutputs();
        #1;
    endtask

    task automatic waitReady();
        while (edgeNum + 1 < busyUntil) step(buildCmd(ddrCmdPkg::OpNop), 1'b0);
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------
    initial begin
        int kind;
        void'($urandom(32'h3f6d47f3));
        rst_n    = 1'b0;
        cmd      = buildCmd(ddrCmdPkg::OpNop);
        cfgWrite = 1'b0;
        cfgSel   = bankPkg::SelTcl;
        cfgValue = '0;
        wrBeat   = '0;
        for (int b = 0; b < bankPkg::BurstLength; b++) modelMem[b] = 64'(b);
        tCl  = bankPkg::DefTcl;
        tCwl = bankPkg::DefTcwl;
        tRcd = bankPkg::DefTrcd;
        tRp  = bankPkg::DefTrp;
        tRfc = bankPkg::DefTrfc;
        rowOpen      = 1'b0;
        busyUntil    = 0;
        burstBase    = -1000;
        burstIsWrite = 1'b0;
        edgeNum      = 0;
        expRead      = 1'b0;
        expWrite     = 1'b0;
        expIdx       = 0;
        dataErrs     = 0;
        readErrs     = 0;
        writeErrs    = 0;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // Reset contents come back first
        step(buildCmd(ddrCmdPkg::OpActivate), 1'b0);
        waitReady();
        step(buildCmd(ddrCmdPkg::OpRead), 1'b0);

        for (int n = 0; n < NumOps; n++) begin
            kind = $urandom % 10;
            if (kind < 6) begin
                waitReady();
                step(buildCmd(pickLegalOp()), 1'b0);
            end else if (kind < 7) begin
                // Legal command one edge before the bank is free again
                while (edgeNum + 2 < busyUntil) step(buildCmd(ddrCmdPkg::OpNop), 1'b0);
                step(buildCmd(pickLegalOp()), 1'b0);
            end else if (kind < 9) begin
                // Any opcode issued early or in the wrong state
                step(buildCmd(ddrCmdPkg::ddrOp_t'(3'($urandom))), 1'b0);
            end else if (!rowOpen) begin
                waitReady();
                step(buildCmd(ddrCmdPkg::OpNop), 1'b1);
            end else begin
                // Raw pins including deselected and reserved patterns
                step(ddrCmdPkg::ddrCmd_t'(21'($urandom)), 1'b0);
            end
            repeat ($urandom % 3) step(buildCmd(ddrCmdPkg::OpNop), 1'b0);
        end
        waitReady();
        repeat (4) step(buildCmd(ddrCmdPkg::OpNop), 1'b0);

        $display("Errors: rdData %0d, readValid %0d, writeValid %0d",
                 dataErrs, readErrs, writeErrs);
        if (dataErrs + readErrs + writeErrs == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
design/ddrCmdPkg.sv
design/bankPkg.sv
design/cmdDecoder.sv
design/timingRegs.sv
design/bankFsm.sv
design/burstStorage.sv
design/memoryBank.sv
verif/memoryBankTb.sv
